/* Makefile */
TOP := conv_tb
OBJ := obj_dir
LOG := sim.log

SOURCES := src.f $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): $(SOURCES)
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

/* rtl/conv_defines.svh */
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// frame geometry.
`define CONV_IX 28
`define CONV_IY 28

// kernel geometry.
`define CONV_KX 5
`define CONV_KY 5
`define CONV_TAPS (`CONV_KX * `CONV_KY)

// coefficient index of the bias word.
`define CONV_BIAS_IDX 25

// data widths.
`define CONV_PIX_W 8
`define CONV_COEF_W 8
`define CONV_ACC_W 24

// scale-down applied before saturation.
`define CONV_OUT_SHIFT 7

`endif

/* rtl/conv_engine_top.sv */
`timescale 1ns/10ps
`include "conv_defines.svh"

module conv_engine_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_pixel_valid,
    input  conv_pixel_pkg::pixel_beat_t i_pixel,
    input  logic                        i_coef_valid,
    input  conv_result_pkg::coef_wr_t   i_coef,
    output logic                        o_result_valid,
    output conv_result_pkg::result_t    o_result
);
    import conv_pixel_pkg::*;
    import conv_result_pkg::*;

    logic      window_valid;
    window_t   window;
    logic      acc_valid;
    acc_beat_t acc;

    conv_line_buffer i_conv_line_buffer (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_pixel_valid  (i_pixel_valid),
        .i_pixel        (i_pixel),
        .o_window_valid (window_valid),
        .o_window       (window)
    );

    conv_mac_array i_conv_mac_array (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_coef_valid   (i_coef_valid),
        .i_coef         (i_coef),
        .i_window_valid (window_valid),
        .i_window       (window),
        .o_acc_valid    (acc_valid),
        .o_acc          (acc)
    );

    conv_relu_output i_conv_relu_output (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_acc_valid    (acc_valid),
        .i_acc          (acc),
        .o_result_valid (o_result_valid),
        .o_result       (o_result)
    );

endmodule

/* rtl/conv_line_buffer.sv */
`timescale 1ns/10ps
`include "conv_defines.svh"

module conv_line_buffer (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_pixel_valid,
    input  conv_pixel_pkg::pixel_beat_t i_pixel,
    output logic                        o_window_valid,
    output conv_pixel_pkg::window_t     o_window
);
    import conv_pixel_pkg::*;

    localparam coord_x_t LAST_COL = coord_x_t'(`CONV_IX - 1);
    localparam coord_y_t LAST_ROW = coord_y_t'(`CONV_IY - 1);
    localparam coord_x_t EDGE_X   = coord_x_t'(`CONV_KX - 1);
    localparam coord_y_t EDGE_Y   = coord_y_t'(`CONV_KY - 1);

    coord_x_t col_cnt;
    coord_y_t row_cnt;

    // previous KY-1 lines, index 0 is the oldest.
    pixel_t   line_mem [`CONV_KY-1][`CONV_IX];
    pixel_t   col_vec  [`CONV_KY];
    window_t  win_q;
    logic     win_full;
    logic     win_valid_q;

    assign win_full = (col_cnt >= EDGE_X) && (row_cnt >= EDGE_Y);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_pixel_valid) begin
            if (col_cnt == LAST_COL) begin
                col_cnt <= '0;
                if (row_cnt == LAST_ROW) begin
                    row_cnt <= '0; // frame done, next strobe starts a new one.
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // vertical column at the current x, new pixel at the bottom.
    always_comb begin
        for (int k = 0; k < `CONV_KY - 1; k++) begin
            col_vec[k] = line_mem[k][col_cnt];
        end
        col_vec[`CONV_KY-1] = i_pixel.pix;
    end

    always_ff @(posedge clk) begin
        if (i_pixel_valid) begin
            for (int k = 0; k < `CONV_KY - 2; k++) begin
                line_mem[k][col_cnt] <= line_mem[k+1][col_cnt];
            end
            line_mem[`CONV_KY-2][col_cnt] <= i_pixel.pix;
        end
    end

    // window slides left one column per strobe.
    always_ff @(posedge clk) begin
        if (i_pixel_valid) begin
            for (int r = 0; r < `CONV_KY; r++) begin
                for (int c = 0; c < `CONV_KX - 1; c++) begin
                    win_q.pix[r][c] <= win_q.pix[r][c+1];
                end
                win_q.pix[r][`CONV_KX-1] <= col_vec[r];
            end
            win_q.ox <= col_cnt - EDGE_X;
            win_q.oy <= row_cnt - EDGE_Y;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win_valid_q <= 1'b0;
        end else begin
            win_valid_q <= i_pixel_valid && win_full;
        end
    end

    assign o_window_valid = win_valid_q;
    assign o_window       = win_q;

    a_col_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        col_cnt < coord_x_t'(`CONV_IX)
    );

endmodule

/* rtl/conv_mac_array.sv */
`timescale 1ns/10ps
`include "conv_defines.svh"

module conv_mac_array (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_coef_valid,
    input  conv_result_pkg::coef_wr_t   i_coef,
    input  logic                        i_window_valid,
    input  conv_pixel_pkg::window_t     i_window,
    output logic                        o_acc_valid,
    output conv_result_pkg::acc_beat_t  o_acc
);
    import conv_pixel_pkg::*;
    import conv_result_pkg::*;

    // unsigned pixel extended by one bit times signed weight.
    localparam int PROD_W = `CONV_PIX_W + 1 + `CONV_COEF_W;
    localparam logic [4:0] BIAS_IDX = 5'(`CONV_BIAS_IDX);

    typedef logic signed [PROD_W-1:0] prod_t;

    coef_t     weight_q [`CONV_TAPS];
    coef_t     bias_q;

    prod_t     prod_q    [`CONV_TAPS];
    acc_t      row_sum_d [`CONV_KY];
    acc_t      row_sum_q [`CONV_KY];
    acc_t      total_d;
    coord_x_t  ox_s1;
    coord_y_t  oy_s1;
    coord_x_t  ox_s2;
    coord_y_t  oy_s2;
    acc_beat_t acc_q;
    logic [2:0] vld_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                weight_q[i] <= '0;
            end
            bias_q <= '0;
        end else if (i_coef_valid) begin
            if (i_coef.idx == BIAS_IDX) begin
                bias_q <= i_coef.value;
            end else if (i_coef.idx < BIAS_IDX) begin
                weight_q[i_coef.idx] <= i_coef.value;
            end
        end
    end

    // stage 1 registers the products.
    always_ff @(posedge clk) begin
        for (int r = 0; r < `CONV_KY; r++) begin
            for (int c = 0; c < `CONV_KX; c++) begin
                prod_q[r*`CONV_KX+c] <= $signed({1'b0, i_window.pix[r][c]})
                                        * weight_q[r*`CONV_KX+c];
            end
        end
        ox_s1 <= i_window.ox;
        oy_s1 <= i_window.oy;
    end

    // stage 2 forms one partial sum per window row.
    always_comb begin
        for (int r = 0; r < `CONV_KY; r++) begin
            row_sum_d[r] = '0;
            for (int c = 0; c < `CONV_KX; c++) begin
                row_sum_d[r] = row_sum_d[r] + acc_t'(prod_q[r*`CONV_KX+c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < `CONV_KY; r++) begin
            row_sum_q[r] <= row_sum_d[r];
        end
        ox_s2 <= ox_s1;
        oy_s2 <= oy_s1;
    end

    // stage 3 adds the row sums and the bias.
    always_comb begin
        total_d = acc_t'(bias_q);
        for (int r = 0; r < `CONV_KY; r++) begin
            total_d = total_d + row_sum_q[r];
        end
    end

    always_ff @(posedge clk) begin
        acc_q.sum <= total_d;
        acc_q.ox  <= ox_s2;
        acc_q.oy  <= oy_s2;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[1:0], i_window_valid};
        end
    end

    assign o_acc_valid = vld_q[2];
    assign o_acc       = acc_q;

    a_coef_idx: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_coef_valid |-> (i_coef.idx <= BIAS_IDX)
    );

endmodule

/* rtl/conv_pixel_pkg.sv */
`include "conv_defines.svh"

package conv_pixel_pkg;

    // unsigned grayscale sample.
    typedef logic [`CONV_PIX_W-1:0] pixel_t;

    // output coordinates, top-left of the window.
    typedef logic [4:0] coord_x_t;
    typedef logic [4:0] coord_y_t;

    typedef struct packed {
        pixel_t pix;
    } pixel_beat_t;

    // pix[row][col], row 0 is the oldest line and col 0 the leftmost column.
    typedef struct packed {
        pixel_t [`CONV_KY-1:0][`CONV_KX-1:0] pix;
        coord_x_t                            ox;
        coord_y_t                            oy;
    } window_t;

endpackage

/* rtl/conv_relu_output.sv */
`timescale 1ns/10ps
`include "conv_defines.svh"

module conv_relu_output (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_acc_valid,
    input  conv_result_pkg::acc_beat_t  i_acc,
    output logic                        o_result_valid,
    output conv_result_pkg::result_t    o_result
);
    import conv_result_pkg::*;

    localparam acc_t SAT_MAX = acc_t'((1 << `CONV_PIX_W) - 1);

    acc_t                   shifted;
    logic [`CONV_PIX_W-1:0] value_d;
    result_t                result_q;
    logic                   valid_q;

    always_comb begin
        shifted = i_acc.sum >>> `CONV_OUT_SHIFT;
        if (i_acc.sum[`CONV_ACC_W-1]) begin
            value_d = '0; // relu.
        end else if (shifted > SAT_MAX) begin
            value_d = '1;
        end else begin
            value_d = shifted[`CONV_PIX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        result_q.value <= value_d;
        result_q.ox    <= i_acc.ox;
        result_q.oy    <= i_acc.oy;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_acc_valid;
        end
    end

    assign o_result_valid = valid_q;
    assign o_result       = result_q;

endmodule

/* rtl/conv_result_pkg.sv */
`include "conv_defines.svh"

package conv_result_pkg;

    typedef logic signed [`CONV_COEF_W-1:0] coef_t;

    // idx 0..24 weights in row-major order, 25 is the bias.
    typedef struct packed {
        logic [4:0] idx;
        coef_t      value;
    } coef_wr_t;

    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    typedef struct packed {
        acc_t                      sum;
        conv_pixel_pkg::coord_x_t  ox;
        conv_pixel_pkg::coord_y_t  oy;
    } acc_beat_t;

    typedef struct packed {
        logic [`CONV_PIX_W-1:0]    value;
        conv_pixel_pkg::coord_x_t  ox;
        conv_pixel_pkg::coord_y_t  oy;
    } result_t;

endpackage

/* src.f */
+incdir+rtl
rtl/conv_pixel_pkg.sv
rtl/conv_result_pkg.sv
rtl/conv_line_buffer.sv
rtl/conv_mac_array.sv
rtl/conv_relu_output.sv
rtl/conv_engine_top.sv
verification/conv_tb_clock.sv
verification/conv_tb.sv

/* verification/conv_tb.sv */
`timescale 1ns/10ps
`include "conv_defines.svh"

module conv_tb;
    import conv_pixel_pkg::*;
    import conv_result_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int GAP_MAX      = 3;
    localparam int LATENCY      = 5;
    localparam int FRAME_PIX    = `CONV_IX * `CONV_IY;
    localparam int FRAME_OUT    = (`CONV_IX - `CONV_KX + 1) * (`CONV_IY - `CONV_KY + 1);
    localparam int TOTAL_FRAMES = 6;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_PIX * 2 * GAP_MAX + 1000;

    localparam int COEF_RANDOM = 0;
    localparam int COEF_NEG    = 1;
    localparam int COEF_SAT    = 2;
    localparam int PIX_RANDOM  = 0;
    localparam int PIX_BRIGHT  = 1;

    logic        clk;
    logic        reset_n;
    logic        pixel_valid;
    pixel_beat_t pixel;
    logic        coef_valid;
    coef_wr_t    coef;
    logic        result_valid;
    result_t     result;

    integer  seed;
    int      model_w [`CONV_TAPS];
    int      model_bias;
    int      img [`CONV_IY][`CONV_IX]; // current frame as seen by the model.
    result_t exp_q [$];
    time     strobe_q [$];            // times of the window-completing strobes.
    result_t exp_r;
    time     sent_at;

    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int test_err_base;
    int result_cnt;
    int min_value;
    int max_value;

    conv_tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_conv_tb_clock (.o_clk(clk));

    conv_engine_top i_conv_engine_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .i_pixel_valid  (pixel_valid),
        .i_pixel        (pixel),
        .i_coef_valid   (coef_valid),
        .i_coef         (coef),
        .o_result_valid (result_valid),
        .o_result       (result)
    );

    task automatic compare_result(input string name, input result_t exp, input result_t act);
        if (act.value !== exp.value || act.ox !== exp.ox || act.oy !== exp.oy) begin
            $display("ERROR %0t %s: expected %0d at (%0d,%0d), actual %0d at (%0d,%0d)",
                     $time, name, exp.value, exp.ox, exp.oy, act.value, act.ox, act.oy);
            err_cnt++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %0t %s: expected %0d, actual %0d", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // convolution, relu, scale and clamp straight from the frame buffer.
    function automatic result_t expected_result(input int ox, input int oy);
        result_t r;
        int      sum;
        int      scaled;
        sum = model_bias;
        for (int ky = 0; ky < `CONV_KY; ky++) begin
            for (int kx = 0; kx < `CONV_KX; kx++) begin
                sum += model_w[ky*`CONV_KX+kx] * img[oy+ky][ox+kx];
            end
        end
        if (sum < 0) begin
            scaled = 0;
        end else begin
            scaled = sum / (1 << `CONV_OUT_SHIFT);
            if (scaled > 255) scaled = 255;
        end
        r.value = 8'(scaled);
        r.ox    = coord_x_t'(ox);
        r.oy    = coord_y_t'(oy);
        return r;
    endfunction

    task automatic write_coef(input int idx, input int value);
        @(negedge clk);
        coef_valid = 1'b1;
        coef.idx   = 5'(idx);
        coef.value = coef_t'(value);
        if (idx == `CONV_BIAS_IDX) model_bias = value;
        else model_w[idx] = value;
    endtask

    task automatic load_coefs(input int mode);
        int v;
        for (int i = 0; i <= `CONV_BIAS_IDX; i++) begin
            v = $random(seed);
            case (mode)
                COEF_NEG: v = (i == `CONV_BIAS_IDX) ? -(v & 127) : -1 - (v & 127);
                COEF_SAT: v = (i == `CONV_BIAS_IDX) ? 1 + (v & 63) : 127;
                default:  v = int'(coef_t'(v));
            endcase
            write_coef(i, v);
        end
        @(negedge clk);
        coef_valid = 1'b0;
    endtask

    task automatic send_pixel(input int x, input int y, input int value);
        @(negedge clk);
        pixel_valid = 1'b1;
        pixel.pix   = pixel_t'(value);
        img[y][x]   = value;
        if (x >= `CONV_KX - 1 && y >= `CONV_KY - 1) begin
            exp_q.push_back(expected_result(x - (`CONV_KX - 1), y - (`CONV_KY - 1)));
            strobe_q.push_back($time);
        end
    endtask

    task automatic send_frame(input int gap_max, input int pix_mode);
        int v;
        int gap;
        for (int y = 0; y < `CONV_IY; y++) begin
            for (int x = 0; x < `CONV_IX; x++) begin
                v = $random(seed);
                v = (pix_mode == PIX_BRIGHT) ? 192 + (v & 63) : (v & 255);
                send_pixel(x, y, v);
                gap = $unsigned($random(seed)) % (gap_max + 1);
                if (gap > 0) begin
                    @(negedge clk);
                    pixel_valid = 1'b0;
                    repeat (gap - 1) @(negedge clk);
                end
            end
        end
        @(negedge clk);
        pixel_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (LATENCY + 1) @(negedge clk); // room for a stray strobe.
    endtask

    task automatic start_test();
        test_err_base = err_cnt;
        result_cnt    = 0;
        min_value     = 255;
        max_value     = 0;
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == test_err_base) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_err_base);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (reset_n && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("%0t: result strobe at (%0d,%0d) arrived with no result expected",
                         $time, result.ox, result.oy);
                err_cnt++;
            end else begin
                exp_r   = exp_q.pop_front();
                sent_at = strobe_q.pop_front();
                compare_result("o_result", exp_r, result);
                compare_count("o_result_valid latency", LATENCY,
                              int'(($time - sent_at) / CLK_PERIOD));
                result_cnt++;
                if (int'(result.value) < min_value) min_value = int'(result.value);
                if (int'(result.value) > max_value) max_value = int'(result.value);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed        = 32'hbfce_8deb;
        reset_n     = 1'b0;
        pixel_valid = 1'b0;
        pixel       = '0;
        coef_valid  = 1'b0;
        coef        = '0;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        model_bias  = 0;
        for (int i = 0; i < `CONV_TAPS; i++) model_w[i] = 0; // matches coefficient reset.

        start_test();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_count("o_result_valid", 0, int'(result_valid));
        end
        reset_n = 1'b1;
        repeat (20) begin
            @(negedge clk);
            compare_count("o_result_valid", 0, int'(result_valid));
        end
        finish_test("reset_state");

        start_test();
        load_coefs(COEF_RANDOM);
        send_frame(GAP_MAX, PIX_RANDOM);
        wait_drain();
        compare_count("results per frame", FRAME_OUT, result_cnt);
        finish_test("random_frame_with_gaps");

        start_test();
        load_coefs(COEF_NEG);
        send_frame(GAP_MAX, PIX_RANDOM);
        wait_drain();
        compare_count("results per frame", FRAME_OUT, result_cnt);
        compare_count("largest result value", 0, max_value);
        finish_test("relu_clamp");

        start_test();
        load_coefs(COEF_SAT);
        send_frame(GAP_MAX, PIX_BRIGHT);
        wait_drain();
        compare_count("results per frame", FRAME_OUT, result_cnt);
        compare_count("smallest result value", 255, min_value);
        finish_test("saturation");

        // no reset and no drain between frames.
        start_test();
        load_coefs(COEF_RANDOM);
        send_frame(0, PIX_RANDOM);
        load_coefs(COEF_RANDOM);
        send_frame(0, PIX_RANDOM);
        wait_drain();
        compare_count("results over two frames", 2 * FRAME_OUT, result_cnt);
        finish_test("back_to_back_frames");

        start_test();
        load_coefs(COEF_RANDOM);
        send_frame(GAP_MAX, PIX_RANDOM);
        wait_drain();
        compare_count("results per frame", FRAME_OUT, result_cnt);
        finish_test("fixed_latency");

        $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/conv_tb_clock.sv */
`timescale 1ns/10ps

module conv_tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0; // first rising edge after half a period.
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

endmodule
